/* ctrl_parser.sv */
`include "key_extract_defs.svh"

module ctrl_parser
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ctrl_data_t c_s_data,
    input  logic       c_s_valid,
    input  logic       c_s_last,
    output ctrl_data_t c_m_data,
    output logic       c_m_valid,
    output logic       c_m_last,
    table_wr_if.master wr
);

    ctrl_state_e          state;
    logic [`TENANT_W-1:0] cur_idx;
    logic [7:0]           mod_id;
    table_sel_e           tbl_sel;
    logic                 hdr_match;

    assign mod_id    = c_s_data[HDR_MOD_MSB:HDR_MOD_LSB];
    assign tbl_sel   = table_sel_e'(c_s_data[HDR_SEL_MSB:HDR_SEL_LSB]);
    // upper five bits name the stage, lower three the module
    assign hdr_match = (mod_id[7:3] == 5'(`STAGE_ID)) && (mod_id[2:0] == 3'(`KEY_EX_ID));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= CTRL_IDLE;
            cur_idx    <= '0;
            wr.idx     <= '0;
            wr.off_we  <= 1'b0;
            wr.mask_we <= 1'b0;
            c_m_data   <= '0;
            c_m_valid  <= 1'b0;
            c_m_last   <= 1'b0;
        end else begin
            wr.off_we  <= 1'b0;
            wr.mask_we <= 1'b0;
            c_m_valid  <= 1'b0;
            c_m_last   <= 1'b0;
            case (state)
                CTRL_IDLE: begin
                    if (c_s_valid && hdr_match) begin
                        // header for us, consumed here
                        cur_idx <= c_s_data[HDR_IDX_MSB:HDR_IDX_LSB];
                        if (!c_s_last) begin
                            state <= (tbl_sel == TBL_OFFSET) ? CTRL_WRITE_OFFSET
                                                             : CTRL_WRITE_MASK;
                        end
                    end else if (c_s_valid) begin
                        c_m_data  <= c_s_data;
                        c_m_valid <= 1'b1;
                        c_m_last  <= c_s_last;
                        if (!c_s_last) begin
                            state <= CTRL_FORWARD;
                        end
                    end
                end
                CTRL_FORWARD: begin
                    if (c_s_valid) begin
                        c_m_data  <= c_s_data;
                        c_m_valid <= 1'b1;
                        c_m_last  <= c_s_last;
                        if (c_s_last) begin
                            state <= CTRL_IDLE;
                        end
                    end
                end
                default: begin
                    // one table entry per data beat, index counts up
                    if (c_s_valid) begin
                        wr.off_we  <= (state == CTRL_WRITE_OFFSET);
                        wr.mask_we <= (state == CTRL_WRITE_MASK);
                        wr.idx     <= cur_idx;
                        cur_idx    <= cur_idx + 1'b1;
                        if (c_s_last) begin
                            state <= CTRL_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    // entry payload, taken from the low bits of the beat
    always_ff @(posedge clk) begin
        if (c_s_valid) begin
            wr.data <= c_s_data[`KEY_LEN-1:0];
        end
    end

    a_no_fwd_after_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state inside {CTRL_WRITE_OFFSET, CTRL_WRITE_MASK}) |=> !c_m_valid
    ) else $error("table write beat leaked onto the forward stream");

endmodule

/* ctrl_pkg.sv */
`include "key_extract_defs.svh"

package ctrl_pkg;

    typedef logic [`CTRL_W-1:0] ctrl_data_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_FORWARD,
        CTRL_WRITE_OFFSET,
        CTRL_WRITE_MASK
    } ctrl_state_e;

    // anything other than the offset code goes to the mask table
    typedef enum logic [3:0] {
        TBL_OFFSET = 4'd0,
        TBL_MASK   = 4'd1
    } table_sel_e;

    // header beat fields
    localparam int HDR_MOD_MSB = 119;
    localparam int HDR_MOD_LSB = 112;
    localparam int HDR_SEL_MSB = 123;
    localparam int HDR_SEL_LSB = 120;
    localparam int HDR_IDX_MSB = 131;
    localparam int HDR_IDX_LSB = 128;

endpackage

/* key_builder.sv */
`include "key_extract_defs.svh"

module key_builder
    import phv_fmt_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    extract_if.dst     ext,
    input  off_entry_t off_entry,
    output key_t       key,
    output logic       key_valid
);

    // low byte of every container, one row per width class, zero row last
    logic [3:0][`CONT_NUM-1:0][7:0] low_byte;

    cont_class_e            cls_a;
    cont_class_e            cls_b;
    logic [`CONT_IDX_W-1:0] idx_a;
    logic [`CONT_IDX_W-1:0] idx_b;
    logic [7:0]             opnd_a;
    logic [7:0]             opnd_b;
    cmp_op_e                op;
    logic                   cmp_res;
    logic [`CMP_NUM-1:0]    cmp_bits;
    key_t                   key_next;

    always_comb begin
        for (int i = 0; i < `CONT_NUM; i++) begin
            low_byte[CLS_2B][i]   = ext.cont2[i][7:0];
            low_byte[CLS_4B][i]   = ext.cont4[i][7:0];
            low_byte[CLS_6B][i]   = ext.cont6[i][7:0];
            low_byte[CLS_ZERO][i] = 8'h00;
        end
    end

    // bit 17 and bit 8 pick an immediate over a container byte
    assign cls_a  = cont_class_e'(ext.cmp_word[13:12]);
    assign idx_a  = ext.cmp_word[11:9];
    assign cls_b  = cont_class_e'(ext.cmp_word[4:3]);
    assign idx_b  = ext.cmp_word[2:0];
    assign opnd_a = ext.cmp_word[17] ? ext.cmp_word[16:9] : low_byte[cls_a][idx_a];
    assign opnd_b = ext.cmp_word[8]  ? ext.cmp_word[7:0]  : low_byte[cls_b][idx_b];
    assign op     = cmp_op_e'(ext.cmp_word[19:18]);

    always_comb begin
        case (op)
            CMP_GT:  cmp_res = (opnd_a > opnd_b);
            CMP_GE:  cmp_res = (opnd_a >= opnd_b);
            CMP_EQ:  cmp_res = (opnd_a == opnd_b);
            default: cmp_res = 1'b1;
        endcase
    end

    // only this stage's comparator slot carries a result
    always_comb begin
        cmp_bits = '0;
        cmp_bits[`CMP_NUM-1-`STAGE_ID] = cmp_res;
    end

    assign key_next = {ext.cont6[off_entry.c6_a], ext.cont6[off_entry.c6_b],
                       ext.cont4[off_entry.c4_a], ext.cont4[off_entry.c4_b],
                       ext.cont2[off_entry.c2_a], ext.cont2[off_entry.c2_b],
                       cmp_bits};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key       <= '0;
            key_valid <= 1'b0;
        end else if (ext.stage_valid) begin
            key       <= key_next;
            key_valid <= 1'b1;
        end else begin
            key       <= '0;
            key_valid <= 1'b0;
        end
    end

    // an invalid key carries no container data
    a_idle_key_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        !key_valid |-> (key == '0)
    ) else $error("key not zero while key_valid is low");

endmodule

/* key_extract_defs.svh */
`ifndef KEY_EXTRACT_DEFS_SVH
`define KEY_EXTRACT_DEFS_SVH

// packet header vector and key widths
`define PHV_LEN         1124
`define KEY_LEN         197

// container layout, eight per width class
`define CONT_NUM        8
`define CONT_IDX_W      3
`define W6B             48
`define W4B             32
`define W2B             16

// comparator words sit right below the 2-byte containers
`define CMP_OP_LEN      20
`define CMP_OP_MSB      355
`define CMP_NUM         5

// tenant field inside the metadata
`define TENANT_LSB      133
`define TENANT_W        4

// per-tenant tables
`define TABLE_DEPTH     16
`define OFF_ENTRY_LEN   18

// control stream
`define CTRL_W          256

// position of this block in the pipeline
`define STAGE_ID        0
`define KEY_EX_ID       1

`endif

/* key_extract_ifs.sv */
`include "key_extract_defs.svh"

// containers and comparator word of one PHV, one cycle before the key
interface extract_if
    import phv_fmt_pkg::*;
;
    cont6_t    cont6 [`CONT_NUM];
    cont4_t    cont4 [`CONT_NUM];
    cont2_t    cont2 [`CONT_NUM];
    cmp_word_t cmp_word;
    logic      stage_valid;

    modport src (
        output cont6, cont4, cont2, cmp_word, stage_valid
    );

    modport dst (
        input cont6, cont4, cont2, cmp_word, stage_valid
    );
endinterface

// write port of the tenant tables
interface table_wr_if
    import phv_fmt_pkg::*;
;
    logic                 off_we;
    logic                 mask_we;
    logic [`TENANT_W-1:0] idx;
    key_t                 data;

    modport master (
        output off_we, mask_we, idx, data
    );

    modport slave (
        input off_we, mask_we, idx, data
    );
endinterface

/* key_extract_top.f */
+incdir+.
phv_fmt_pkg.sv
ctrl_pkg.sv
key_extract_ifs.sv
phv_pipeline.sv
key_builder.sv
tenant_tables.sv
ctrl_parser.sv
key_extract_top.sv
tb_key_extract.sv

/* key_extract_top.sv */
`include "key_extract_defs.svh"

module key_extract_top
    import phv_fmt_pkg::*;
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  phv_t       phv_in,
    input  logic       phv_valid_in,
    output phv_t       phv_out,
    output logic       phv_valid_out,
    output key_t       key,
    output logic       key_valid,
    output key_t       key_mask,
    input  ctrl_data_t c_s_data,
    input  logic       c_s_valid,
    input  logic       c_s_last,
    output ctrl_data_t c_m_data,
    output logic       c_m_valid,
    output logic       c_m_last
);

    extract_if  ext_if ();
    table_wr_if wr_if ();

    logic [`TENANT_W-1:0] tenant;
    off_entry_t           off_entry;

    phv_pipeline u_phv_pipeline (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv_in        (phv_in),
        .phv_valid_in  (phv_valid_in),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .tenant        (tenant),
        .ext           (ext_if.src)
    );

    key_builder u_key_builder (
        .clk       (clk),
        .rst_n     (rst_n),
        .ext       (ext_if.dst),
        .off_entry (off_entry),
        .key       (key),
        .key_valid (key_valid)
    );

    tenant_tables u_tenant_tables (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (wr_if.slave),
        .tenant    (tenant),
        .off_entry (off_entry),
        .key_mask  (key_mask)
    );

    ctrl_parser u_ctrl_parser (
        .clk       (clk),
        .rst_n     (rst_n),
        .c_s_data  (c_s_data),
        .c_s_valid (c_s_valid),
        .c_s_last  (c_s_last),
        .c_m_data  (c_m_data),
        .c_m_valid (c_m_valid),
        .c_m_last  (c_m_last),
        .wr        (wr_if.master)
    );

endmodule

/* phv_fmt_pkg.sv */
`include "key_extract_defs.svh"

package phv_fmt_pkg;

    // whole header vector, containers from the top down, metadata at the bottom
    typedef logic [`PHV_LEN-1:0] phv_t;

    typedef logic [`W6B-1:0] cont6_t;
    typedef logic [`W4B-1:0] cont4_t;
    typedef logic [`W2B-1:0] cont2_t;

    // key and key mask share one layout
    typedef logic [`KEY_LEN-1:0] key_t;

    // raw comparator word, decoded field by field in the key builder
    typedef logic [`CMP_OP_LEN-1:0] cmp_word_t;

    typedef enum logic [1:0] {
        CMP_GT   = 2'd0,
        CMP_GE   = 2'd1,
        CMP_EQ   = 2'd2,
        CMP_TRUE = 2'd3
    } cmp_op_e;

    // width class of a container operand
    typedef enum logic [1:0] {
        CLS_2B   = 2'd0,
        CLS_4B   = 2'd1,
        CLS_6B   = 2'd2,
        CLS_ZERO = 2'd3
    } cont_class_e;

    // container indices, listed in key order
    typedef struct packed {
        logic [`CONT_IDX_W-1:0] c6_a;
        logic [`CONT_IDX_W-1:0] c6_b;
        logic [`CONT_IDX_W-1:0] c4_a;
        logic [`CONT_IDX_W-1:0] c4_b;
        logic [`CONT_IDX_W-1:0] c2_a;
        logic [`CONT_IDX_W-1:0] c2_b;
    } off_entry_t;

endpackage

/* phv_pipeline.sv */
`include "key_extract_defs.svh"

module phv_pipeline
    import phv_fmt_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  phv_t                 phv_in,
    input  logic                 phv_valid_in,
    output phv_t                 phv_out,
    output logic                 phv_valid_out,
    output logic [`TENANT_W-1:0] tenant,
    extract_if.src               ext
);

    localparam int DEPTH  = 4;
    localparam int C6_TOP = `PHV_LEN - 1;
    localparam int C4_TOP = C6_TOP - `CONT_NUM * `W6B;
    localparam int C2_TOP = C4_TOP - `CONT_NUM * `W4B;
    localparam int OP_TOP = `CMP_OP_MSB - `STAGE_ID * `CMP_OP_LEN;

    phv_t             phv_d [DEPTH];
    logic [DEPTH-1:0] valid_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                phv_d[i] <= '0;
            end
            valid_d         <= '0;
            ext.stage_valid <= 1'b0;
        end else begin
            phv_d[0] <= phv_in;
            for (int i = 1; i < DEPTH; i++) begin
                phv_d[i] <= phv_d[i-1];
            end
            valid_d         <= {valid_d[DEPTH-2:0], phv_valid_in};
            ext.stage_valid <= valid_d[1];
        end
    end

    assign phv_out       = phv_d[DEPTH-1];
    assign phv_valid_out = valid_d[DEPTH-1];

    // tenant of the PHV in stage 2, addresses the tables
    assign tenant = phv_d[1][`TENANT_LSB +: `TENANT_W];

    // container 7 of each class sits highest in the PHV
    always_ff @(posedge clk) begin
        for (int i = 0; i < `CONT_NUM; i++) begin
            ext.cont6[i] <= phv_d[1][C6_TOP - (`CONT_NUM-1-i) * `W6B -: `W6B];
            ext.cont4[i] <= phv_d[1][C4_TOP - (`CONT_NUM-1-i) * `W4B -: `W4B];
            ext.cont2[i] <= phv_d[1][C2_TOP - (`CONT_NUM-1-i) * `W2B -: `W2B];
        end
        ext.cmp_word <= phv_d[1][OP_TOP -: `CMP_OP_LEN];
    end

    a_valid_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n, DEPTH) |-> (phv_valid_out == $past(phv_valid_in, DEPTH))
    ) else $error("phv_valid_out does not follow phv_valid_in by %0d cycles", DEPTH);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds the key extraction testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_key_extract \
    -f key_extract_top.f \
    --Mdir obj_dir \
    -o sim_key_extract
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_key_extract 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* tb_key_extract.sv */
`include "key_extract_defs.svh"

module tb_key_extract
    import phv_fmt_pkg::*;
    import ctrl_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int C6_BASE    = `PHV_LEN - `CONT_NUM * `W6B;
    localparam int C4_BASE    = C6_BASE - `CONT_NUM * `W4B;
    localparam int C2_BASE    = C4_BASE - `CONT_NUM * `W2B;
    localparam int OP_LSB     = `CMP_OP_MSB - (`STAGE_ID + 1) * `CMP_OP_LEN + 1;
    // several times the length of the whole test sequence
    localparam int MAX_CYCLES = 2000;

    // directed operand pairs {a_imm, a, b_imm, b}, container operands as {junk, class, index}
    localparam logic [17:0] OPERANDS [8] = '{
        {1'b1, 8'h40, 1'b1, 8'h40},
        {1'b1, 8'h41, 1'b1, 8'h40},
        {1'b1, 8'h3f, 1'b1, 8'h40},
        {1'b0, 8'hf2, 1'b1, 8'h80},
        {1'b1, 8'h80, 1'b0, 8'h0d},
        {1'b0, 8'h07, 1'b0, 8'h07},
        {1'b0, 8'h18, 1'b1, 8'h00},
        {1'b0, 8'h11, 1'b0, 8'h0b}
    };

    logic       clk;
    logic       rst_n;
    phv_t       phv_in;
    logic       phv_valid_in;
    phv_t       phv_out;
    logic       phv_valid_out;
    key_t       key;
    logic       key_valid;
    key_t       key_mask;
    ctrl_data_t c_s_data;
    logic       c_s_valid;
    logic       c_s_last;
    ctrl_data_t c_m_data;
    logic       c_m_valid;
    logic       c_m_last;

    // expected values, driven together with the stimulus
    key_t       exp_key;
    key_t       exp_mask;
    logic       fwd_expect;
    int         cycle_count = 0;
    int         error_count = 0;

    logic [`OFF_ENTRY_LEN-1:0] off_model [`TABLE_DEPTH];
    key_t                      mask_model [`TABLE_DEPTH];

    key_extract_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv_in        (phv_in),
        .phv_valid_in  (phv_valid_in),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .key           (key),
        .key_valid     (key_valid),
        .key_mask      (key_mask),
        .c_s_data      (c_s_data),
        .c_s_valid     (c_s_valid),
        .c_s_last      (c_s_last),
        .c_m_data      (c_m_data),
        .c_m_valid     (c_m_valid),
        .c_m_last      (c_m_last)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

    task automatic report_error(input string msg);
        error_count++;
        $display("[ERROR] %0t: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    function automatic logic [1151:0] random_bits();
        logic [1151:0] r;
        r = '0;
        for (int i = 0; i < 36; i++) begin
            r = {r[1119:0], $urandom()};
        end
        return r;
    endfunction

    // low byte of a container operand, class 3 reads as zero
    function automatic logic [7:0] operand_byte(phv_t p, logic [1:0] cls, logic [2:0] idx);
        case (cls)
            2'd0:    return p[C2_BASE + int'(idx) * `W2B +: 8];
            2'd1:    return p[C4_BASE + int'(idx) * `W4B +: 8];
            2'd2:    return p[C6_BASE + int'(idx) * `W6B +: 8];
            default: return 8'h00;
        endcase
    endfunction

    function automatic key_t expected_key(phv_t p, logic [`OFF_ENTRY_LEN-1:0] e);
        logic [`CMP_OP_LEN-1:0] w;
        logic [7:0]             a;
        logic [7:0]             b;
        logic                   res;
        key_t                   k;
        w = p[OP_LSB +: `CMP_OP_LEN];
        a = w[17] ? w[16:9] : operand_byte(p, w[13:12], w[11:9]);
        b = w[8] ? w[7:0] : operand_byte(p, w[4:3], w[2:0]);
        case (w[19:18])
            2'd0:    res = (a > b);
            2'd1:    res = (a >= b);
            2'd2:    res = (a == b);
            default: res = 1'b1;
        endcase
        // six fields in entry order, then the comparator slots
        k = {p[C6_BASE + int'(e[17:15]) * `W6B +: `W6B],
             p[C6_BASE + int'(e[14:12]) * `W6B +: `W6B],
             p[C4_BASE + int'(e[11:9]) * `W4B +: `W4B],
             p[C4_BASE + int'(e[8:6]) * `W4B +: `W4B],
             p[C2_BASE + int'(e[5:3]) * `W2B +: `W2B],
             p[C2_BASE + int'(e[2:0]) * `W2B +: `W2B],
             `CMP_NUM'(0)};
        k[`CMP_NUM-1-`STAGE_ID] = res;
        return k;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic send_ctrl_beat(input ctrl_data_t data, input logic last, input logic fwd);
        c_s_data   = data;
        c_s_valid  = 1'b1;
        c_s_last   = last;
        fwd_expect = fwd;
        tick();
    endtask

    task automatic release_ctrl();
        c_s_valid  = 1'b0;
        c_s_last   = 1'b0;
        fwd_expect = 1'b0;
    endtask

    // header beat addressed to this block, then one entry per beat
    task automatic write_table(input logic [3:0] sel, input logic [3:0] start, input int count);
        ctrl_data_t hdr;
        ctrl_data_t beat;
        logic [3:0] idx;
        hdr = ctrl_data_t'(random_bits());
        hdr[HDR_MOD_MSB:HDR_MOD_LSB] = {5'(`STAGE_ID), 3'(`KEY_EX_ID)};
        hdr[HDR_SEL_MSB:HDR_SEL_LSB] = sel;
        hdr[HDR_IDX_MSB:HDR_IDX_LSB] = start;
        send_ctrl_beat(hdr, count == 0, 1'b0);
        idx = start;
        for (int i = 0; i < count; i++) begin
            beat = ctrl_data_t'(random_bits());
            if (sel == 4'd0) begin
                off_model[idx] = beat[`OFF_ENTRY_LEN-1:0];
            end else begin
                mask_model[idx] = beat[`KEY_LEN-1:0];
            end
            send_ctrl_beat(beat, i == count - 1, 1'b0);
            idx = idx + 4'd1;
        end
        release_ctrl();
    endtask

    task automatic forward_packet(input logic [7:0] mod_id, input int beats);
        ctrl_data_t hdr;
        hdr = ctrl_data_t'(random_bits());
        hdr[HDR_MOD_MSB:HDR_MOD_LSB] = mod_id;
        send_ctrl_beat(hdr, beats == 1, 1'b1);
        for (int i = 1; i < beats; i++) begin
            if (i == 2) begin
                // gap inside the packet
                release_ctrl();
                tick();
            end
            send_ctrl_beat(ctrl_data_t'(random_bits()), i == beats - 1, 1'b1);
        end
        release_ctrl();
    endtask

    task automatic send_phv(input logic [3:0] tenant, input logic [`CMP_OP_LEN-1:0] word);
        phv_t p;
        p = phv_t'(random_bits());
        p[`TENANT_LSB +: `TENANT_W] = tenant;
        p[OP_LSB +: `CMP_OP_LEN] = word;
        phv_in       = p;
        phv_valid_in = 1'b1;
        exp_key      = expected_key(p, off_model[tenant]);
        exp_mask     = mask_model[tenant];
        tick();
    endtask

    task automatic idle_phv();
        phv_in       = phv_t'(random_bits());
        phv_valid_in = 1'b0;
        tick();
    endtask

    a_phv_delay: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n, 4) |-> (phv_valid_out == $past(phv_valid_in, 4)
                             && phv_out == $past(phv_in, 4))
    ) else report_error("phv_out or phv_valid_out differs from the PHV four cycles back");

    a_key_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        key_valid == phv_valid_out
    ) else report_error("key_valid does not line up with phv_valid_out");

    a_key_value: assert property (
        @(posedge clk) disable iff (!rst_n)
        key_valid |-> key == $past(exp_key, 4)
    ) else report_error("key differs from the expected key");

    a_key_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        !key_valid |-> key == '0
    ) else report_error("key not zero while key_valid is low");

    a_mask_value: assert property (
        @(posedge clk) disable iff (!rst_n)
        key_valid |-> key_mask == $past(exp_mask, 4)
    ) else report_error("key_mask differs from the tenant mask entry");

    a_fwd_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> c_m_valid == $past(fwd_expect)
    ) else report_error("c_m_valid differs from the expected forwarding");

    a_fwd_data: assert property (
        @(posedge clk) disable iff (!rst_n)
        c_m_valid |-> (c_m_data == $past(c_s_data) && c_m_last == $past(c_s_last))
    ) else report_error("forwarded beat differs from the input beat");

    a_reset_state: assert property (
        @(posedge clk)
        $rose(rst_n) |-> (!phv_valid_out && phv_out == '0 && !key_valid && key == '0
                          && key_mask == '0 && !c_m_valid && c_m_data == '0
                          && !c_m_last)
    ) else report_error("outputs not cleared by reset");

    initial begin
        void'($urandom(81));
        rst_n        = 1'b0;
        phv_in       = '0;
        phv_valid_in = 1'b0;
        c_s_data     = '0;
        c_s_valid    = 1'b0;
        c_s_last     = 1'b0;
        fwd_expect   = 1'b0;
        exp_key      = '0;
        exp_mask     = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (4) tick();

        // offset table in two packets, then a header-only packet that writes nothing
        write_table(TBL_OFFSET, 4'd3, 13);
        write_table(TBL_OFFSET, 4'd0, 3);
        write_table(TBL_OFFSET, 4'd5, 0);
        // any select other than the offset code reaches the mask table
        write_table(TBL_MASK, 4'd0, 10);
        write_table(4'd7, 4'd10, 6);
        repeat (4) tick();

        for (int i = 0; i < 96; i++) begin
            send_phv(4'($urandom()), 20'($urandom()));
        end
        for (int i = 0; i < 80; i++) begin
            if ($urandom() % 2 == 1) begin
                send_phv(4'($urandom()), 20'($urandom()));
            end else begin
                idle_phv();
            end
        end
        for (int op = 0; op < 4; op++) begin
            for (int j = 0; j < 8; j++) begin
                send_phv(4'($urandom()), {2'(op), OPERANDS[j]});
            end
        end
        repeat (6) idle_phv();

        // other module in this stage, then the same module in another stage
        forward_packet({5'(`STAGE_ID), 3'd2}, 4);
        forward_packet({5'd3, 3'(`KEY_EX_ID)}, 1);
        forward_packet({5'd9, 3'd6}, 3);
        repeat (3) tick();

        write_table(TBL_MASK, 4'd0, 2);
        repeat (4) tick();
        for (int i = 0; i < 16; i++) begin
            send_phv(4'($urandom()), 20'($urandom()));
        end
        repeat (8) idle_phv();

        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* tenant_tables.sv */
`include "key_extract_defs.svh"

module tenant_tables
    import phv_fmt_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    table_wr_if.slave            wr,
    input  logic [`TENANT_W-1:0] tenant,
    output off_entry_t           off_entry,
    output key_t                 key_mask
);

    off_entry_t off_mem  [`TABLE_DEPTH];
    key_t       mask_mem [`TABLE_DEPTH];
    key_t       mask_rd;

    // write port from the control path
    always_ff @(posedge clk) begin
        if (wr.off_we) begin
            off_mem[wr.idx] <= off_entry_t'(wr.data[`OFF_ENTRY_LEN-1:0]);
        end
        if (wr.mask_we) begin
            mask_mem[wr.idx] <= wr.data;
        end
    end

    // synchronous read at the tenant index
    always_ff @(posedge clk) begin
        off_entry <= off_mem[tenant];
        mask_rd   <= mask_mem[tenant];
    end

    // mask lines up with the key one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_mask <= '0;
        end else begin
            key_mask <= mask_rd;
        end
    end

    a_one_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(wr.off_we && wr.mask_we)
    ) else $error("offset and mask writes in the same cycle");

endmodule
